// File: build.f
+incdir+design
design/rbk_wr_pkg.sv
design/rbk_wr_lane_if.sv
design/rbk_wr_lane_fifo.sv
design/rbk_wr_cmd_fifo.sv
design/rbk_wr_line_split.sv
design/rbk_wr_req_seq.sv
design/rbk_wr_req.sv
tests/tb_clk_gen.sv
tests/tb_rbk_wr_req.sv

// File: run.sh
#!/bin/sh
# compile and run the write request testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_rbk_wr_req -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile step returned an error"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation returned status $sim_status"
  exit 1
fi
exit 0

// File: tests/tb_rbk_wr_req.sv
`timescale 1ns/100ps
`default_nettype none

`include "rbk_wr_defs.svh"

module tb_rbk_wr_req;
  import rbk_wr_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;  // about twice the cycles of all tests
  localparam int RDY_ON         = 0;
  localparam int RDY_RAND       = 1;
  localparam int RDY_OFF        = 2;

  logic       nvdla_core_clk;
  logic       nvdla_core_rstn;
  logic       dma_wr_cmd_vld;
  logic       dma_wr_cmd_rdy;
  cmd_pd_t    dma_wr_cmd_pd;
  logic       dma_wr_data_vld;
  logic       dma_wr_data_rdy;
  line_pd_t   dma_wr_data_pd;
  logic       wr_req_vld;
  logic       wr_req_rdy;
  req_pd_t    wr_req_pd;
  logic       reg2dp_dataout_ram_type;
  logic       wr_req_type;
  logic       dp2reg_done;
  logic       reg2dp_perf_en;
  logic       dp2reg_consumer;
  stall_cnt_t dp2reg_d0_wr_stall_cnt;
  stall_cnt_t dp2reg_d1_wr_stall_cnt;

  // reference model of the packet stream
  req_pd_t    exp_q [$];
  logic       exp_done_q [$];
  req_pd_t    exp_head;
  logic       exp_done_head;
  logic       exp_any = 1'b0;
  int         layer_sizes [$];
  string      test_name = "reset";
  integer     seed = 41;
  int         rdy_mode = RDY_ON;
  logic       rdy_next;
  int         done_cnt = 0;
  int         done_target = 0;
  int         cycle_cnt = 0;
  logic       saw_cmd_full = 1'b0;
  logic       saw_data_full = 1'b0;
  stall_cnt_t stall_model;
  stall_cnt_t stall_exp;
  stall_cnt_t other_exp;
  logic       stall_sel;
  logic       stall_chk;
  stall_cnt_t sel_cnt;
  stall_cnt_t other_cnt;

  tb_clk_gen u_clk_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn)
  );

  rbk_wr_req DUT (.*);

  assign sel_cnt   = stall_sel ? dp2reg_d1_wr_stall_cnt : dp2reg_d0_wr_stall_cnt;
  assign other_cnt = stall_sel ? dp2reg_d0_wr_stall_cnt : dp2reg_d1_wr_stall_cnt;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic refresh_head();
    exp_any       = (exp_q.size() != 0);
    exp_head      = exp_any ? exp_q[0] : '0;
    exp_done_head = exp_any ? exp_done_q[0] : 1'b0;
  endtask

  task automatic add_expected(input req_pd_t pd, input logic ends_layer);
    exp_q.push_back(pd);
    exp_done_q.push_back(ends_layer);
    refresh_head();
  endtask

  // ==========================================================================
  // input drivers called on the falling edge
  // ==========================================================================
  task automatic push_cmd(input cmd_pd_t pd);
    logic taken;
    taken          = 1'b0;
    dma_wr_cmd_vld = 1'b1;
    dma_wr_cmd_pd  = pd;
    while (!taken) begin
      #1 taken = dma_wr_cmd_rdy;  // settled mid low phase
      @(negedge nvdla_core_clk);
    end
    dma_wr_cmd_vld = 1'b0;
  endtask

  task automatic push_line(input line_pd_t pd);
    logic taken;
    taken           = 1'b0;
    dma_wr_data_vld = 1'b1;
    dma_wr_data_pd  = pd;
    while (!taken) begin
      #1 taken = dma_wr_data_rdy;
      @(negedge nvdla_core_clk);
    end
    dma_wr_data_vld = 1'b0;
  endtask

  // one layer from layer_sizes in halves per command
  task automatic run_layer(input string name);
    cmd_pd_t  cmd_q [$];
    line_pd_t line_q [$];
    cmd_pd_t  cmd;
    half_t    lo;
    half_t    hi;
    int       n;
    logic     last;
    test_name = name;
    foreach (layer_sizes[k]) begin
      n    = layer_sizes[k];
      last = (k == layer_sizes.size() - 1);
      cmd  = {last, `RBK_SIZE_W'(n - 1), `RBK_ADDR_W'($random(seed))};
      cmd_q.push_back(cmd);
      add_expected(req_pd_t'(cmd), 1'b0);
      for (int i = 0; i < n; i += 2) begin
        lo = {$random(seed), $random(seed)};
        hi = {$random(seed), $random(seed)};  // dropped for a lone half
        if (i + 1 < n) begin
          line_q.push_back({2'b11, hi, lo});
          add_expected({1'b1, 2'b11, hi, lo}, last && (i + 2 == n));
        end else begin
          line_q.push_back({2'b01, hi, lo});
          add_expected({1'b1, 2'b01, {`RBK_HALF_DW{1'b0}}, lo}, last);
        end
      end
    end
    fork
      foreach (cmd_q[j]) push_cmd(cmd_q[j]);
      foreach (line_q[j]) push_line(line_q[j]);
    join
    done_target++;
    while (done_cnt < done_target) begin
      @(negedge nvdla_core_clk);
    end
  endtask

  // ==========================================================================
  // monitors
  // ==========================================================================
  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      if (wr_req_vld && wr_req_rdy && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        void'(exp_done_q.pop_front());
        refresh_head();
      end
      if (dp2reg_done) begin
        done_cnt++;
      end
      if (dma_wr_cmd_vld && !dma_wr_cmd_rdy) begin
        saw_cmd_full = 1'b1;
      end
      if (dma_wr_data_vld && !dma_wr_data_rdy) begin
        saw_data_full = 1'b1;
      end
    end
  end

  // stall cycles since the previous done
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_model <= '0;
      stall_exp   <= '0;
      other_exp   <= '0;
      stall_sel   <= 1'b0;
      stall_chk   <= 1'b0;
    end else begin
      stall_chk <= dp2reg_done;
      if (dp2reg_done) begin
        stall_exp   <= stall_model;
        stall_sel   <= dp2reg_consumer;
        other_exp   <= dp2reg_consumer ? dp2reg_d0_wr_stall_cnt : dp2reg_d1_wr_stall_cnt;
        stall_model <= '0;
      end else if (reg2dp_perf_en && wr_req_vld && !wr_req_rdy) begin
        stall_model <= stall_model + 1;
      end
    end
  end

  always @(posedge nvdla_core_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("timeout in %s after %0d cycles", test_name, cycle_cnt));
    end
  end

  // next ready drawn on the rising edge, driven on the falling edge
  initial begin
    wr_req_rdy = 1'b0;
    forever begin
      @(posedge nvdla_core_clk);
      case (rdy_mode)
        RDY_ON:   rdy_next = 1'b1;
        RDY_RAND: rdy_next = ($random(seed) & 3) != 0;  // ready three cycles in four
        default:  rdy_next = 1'b0;
      endcase
      @(negedge nvdla_core_clk);
      wr_req_rdy = rdy_next;
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================
  a_pkt_expected: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    wr_req_vld && wr_req_rdy |-> exp_any
  ) else report_failure($sformatf("%s: packet accepted with none expected", test_name));

  a_pkt_match: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    wr_req_vld && wr_req_rdy && exp_any |-> wr_req_pd == exp_head
  ) else report_failure($sformatf("MISMATCH %s packet expected %h actual %h", test_name,
                                  $sampled(exp_head), $sampled(wr_req_pd)));

  a_done_match: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    wr_req_vld && wr_req_rdy && exp_any |-> dp2reg_done == exp_done_head
  ) else report_failure($sformatf("MISMATCH %s done expected %0b actual %0b", test_name,
                                  $sampled(exp_done_head), $sampled(dp2reg_done)));

  a_done_on_pop: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dp2reg_done |-> wr_req_vld && wr_req_rdy
  ) else report_failure($sformatf("%s: done pulsed without an accepted packet", test_name));

  a_vld_held: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    wr_req_vld && !wr_req_rdy |=> wr_req_vld && (wr_req_pd == $past(wr_req_pd))
  ) else report_failure($sformatf("%s: request dropped or changed before accept", test_name));

  a_stall_sel: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    stall_chk |-> sel_cnt == stall_exp
  ) else report_failure($sformatf("MISMATCH %s stall count expected %0d actual %0d",
                                  test_name, $sampled(stall_exp), $sampled(sel_cnt)));

  a_stall_other: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    stall_chk |-> other_cnt == other_exp
  ) else report_failure($sformatf("MISMATCH %s other stall register expected %0d actual %0d",
                                  test_name, $sampled(other_exp), $sampled(other_cnt)));

  // ==========================================================================
  // tests
  // ==========================================================================
  initial begin
    dma_wr_cmd_vld          = 1'b0;
    dma_wr_cmd_pd           = '0;
    dma_wr_data_vld         = 1'b0;
    dma_wr_data_pd          = '0;
    reg2dp_dataout_ram_type = 1'b0;
    reg2dp_perf_en          = 1'b0;
    dp2reg_consumer         = 1'b0;
    wait (nvdla_core_rstn);
    @(negedge nvdla_core_clk);
    if (wr_req_vld || dp2reg_done || !dma_wr_cmd_rdy || !dma_wr_data_rdy) begin
      report_failure("outputs not idle after reset");
    end
    if (wr_req_type !== 1'b0) begin
      report_failure("ram type not passed through");
    end
    reg2dp_dataout_ram_type = 1'b1;
    #1;
    if (wr_req_type !== 1'b1) begin
      report_failure("ram type not passed through");
    end
    @(negedge nvdla_core_clk);

    // counter off from reset so d1 gets the held zero
    rdy_mode    = RDY_RAND;
    dp2reg_consumer = 1'b1;
    layer_sizes = '{5, 2, 3};
    run_layer("perf_off");

    reg2dp_perf_en  = 1'b1;
    dp2reg_consumer = 1'b0;
    rdy_mode        = RDY_ON;
    layer_sizes     = '{4, 2, 6};
    run_layer("basic");

    dp2reg_consumer = 1'b1;
    rdy_mode        = RDY_RAND;
    layer_sizes     = '{3, 1, 5, 7, 3};  // lone halves alternate lanes
    run_layer("odd_run");

    repeat (3) begin
      dp2reg_consumer = (($random(seed) & 1) != 0);
      layer_sizes.delete();
      repeat (4) layer_sizes.push_back(1 + (($random(seed) & 32'h7fffffff) % 12));
      run_layer("random");
    end

    // nothing drains, so both fifos fill and the readys fall
    rdy_mode      = RDY_OFF;
    saw_cmd_full  = 1'b0;
    saw_data_full = 1'b0;
    layer_sizes   = '{4, 6, 3, 5, 2, 8};
    fork
      run_layer("backpressure");
      begin
        repeat (80) @(negedge nvdla_core_clk);
        if (!(saw_cmd_full && saw_data_full)) begin
          report_failure("input readys did not drop under back-pressure");
        end else begin
          rdy_mode = RDY_RAND;
        end
      end
    join

    @(negedge nvdla_core_clk);
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d packets never arrived", exp_q.size()));
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 10
) (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  initial begin
    nvdla_core_clk = 1'b0;
    forever begin
      #(PERIOD / 2) nvdla_core_clk = ~nvdla_core_clk;
    end
  end

  // release away from the rising edge
  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
  end

endmodule

`default_nettype wire

// File: design/rbk_wr_req.sv
`timescale 1ns/100ps
`default_nettype none

`include "rbk_wr_defs.svh"

module rbk_wr_req (
  input  wire                       nvdla_core_clk,
  input  wire                       nvdla_core_rstn,
  input  wire                       dma_wr_cmd_vld,
  output logic                      dma_wr_cmd_rdy,
  input  wire rbk_wr_pkg::cmd_pd_t  dma_wr_cmd_pd,
  input  wire                       dma_wr_data_vld,
  output logic                      dma_wr_data_rdy,
  input  wire rbk_wr_pkg::line_pd_t dma_wr_data_pd,
  output logic                      wr_req_vld,
  input  wire                       wr_req_rdy,
  output rbk_wr_pkg::req_pd_t       wr_req_pd,
  input  wire                       reg2dp_dataout_ram_type,
  output logic                      wr_req_type,
  output logic                      dp2reg_done,
  input  wire                       reg2dp_perf_en,
  input  wire                       dp2reg_consumer,
  output rbk_wr_pkg::stall_cnt_t    dp2reg_d0_wr_stall_cnt,
  output rbk_wr_pkg::stall_cnt_t    dp2reg_d1_wr_stall_cnt
);
  import rbk_wr_pkg::*;

  logic    cmd_vld;
  logic    cmd_rdy;
  cmd_pd_t cmd_pd;

  rbk_wr_lane_if lane [2] ();  // 0 low lane, 1 high lane

  assign wr_req_type = reg2dp_dataout_ram_type;  // ram type passes straight out

  // ==========================================================================
  // buffering
  // ==========================================================================
  rbk_wr_cmd_fifo #(
    .DEPTH (`RBK_CMD_DEPTH)
  ) u_cmd_fifo (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_vld          (dma_wr_cmd_vld),
    .in_rdy          (dma_wr_cmd_rdy),
    .in_pd           (dma_wr_cmd_pd),
    .out_vld         (cmd_vld),
    .out_rdy         (cmd_rdy),
    .out_pd          (cmd_pd)
  );

  rbk_wr_line_split u_split (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .data_vld        (dma_wr_data_vld),
    .data_pd         (dma_wr_data_pd),
    .data_rdy        (dma_wr_data_rdy),
    .lane            (lane),
    .done            (dp2reg_done)
  );

  for (genvar i = 0; i < 2; i++) begin : g_lane
    rbk_wr_lane_fifo u_lane (
      .nvdla_core_clk  (nvdla_core_clk),
      .nvdla_core_rstn (nvdla_core_rstn),
      .lane            (lane[i])
    );
  end

  // request ordering and perf counters
  rbk_wr_req_seq u_seq (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cmd_vld         (cmd_vld),
    .cmd_pd          (cmd_pd),
    .cmd_rdy         (cmd_rdy),
    .lane            (lane),
    .wr_req_rdy      (wr_req_rdy),
    .perf_en         (reg2dp_perf_en),
    .consumer        (dp2reg_consumer),
    .wr_req_vld      (wr_req_vld),
    .wr_req_pd       (wr_req_pd),
    .done            (dp2reg_done),
    .d0_stall_cnt    (dp2reg_d0_wr_stall_cnt),
    .d1_stall_cnt    (dp2reg_d1_wr_stall_cnt)
  );

endmodule

`default_nettype wire

// File: design/rbk_wr_req_seq.sv
`timescale 1ns/100ps
`default_nettype none

`include "rbk_wr_defs.svh"

module rbk_wr_req_seq (
  input  wire                      nvdla_core_clk,
  input  wire                      nvdla_core_rstn,
  input  wire                      cmd_vld,
  input  wire rbk_wr_pkg::cmd_pd_t cmd_pd,
  output logic                     cmd_rdy,
  rbk_wr_lane_if.rd                lane [2],
  input  wire                      wr_req_rdy,
  input  wire                      perf_en,
  input  wire                      consumer,
  output logic                     wr_req_vld,
  output rbk_wr_pkg::req_pd_t      wr_req_pd,
  output logic                     done,
  output rbk_wr_pkg::stall_cnt_t   d0_stall_cnt,
  output rbk_wr_pkg::stall_cnt_t   d1_stall_cnt
);
  import rbk_wr_pkg::*;

  localparam int SW = `RBK_SIZE_W;
  localparam int AW = `RBK_ADDR_W;

  seq_state_e state;
  seq_state_e state_nxt;
  logic       send_half;   // mirrors the splitter fill toggle
  half_cnt_t  buf_cnt;
  half_cnt_t  buf_cnt_nxt;
  half_cnt_t  size_p1;
  logic       last_cmd;
  half_cnt_t  popped_cnt;
  half_cnt_t  popped_nxt;
  half_cnt_t  remain;
  half_cnt_t  push_size;
  half_cnt_t  pop_size;
  line_mask_t pop_mask;
  logic       single;
  logic       cmd_req_vld;
  logic       cmd_pop;
  logic       data_req_vld;
  logic       data_go;
  logic       pop_lo;
  logic       pop_hi;
  logic       data_pop;
  logic       data_done;
  half_t      data_lo;
  half_t      data_hi;
  stall_cnt_t stall_cnt;

  // ==========================================================================
  // buffered halves across both lanes
  // ==========================================================================
  assign push_size = half_cnt_t'(lane[0].push_vld & lane[0].push_rdy)
                   + half_cnt_t'(lane[1].push_vld & lane[1].push_rdy);
  assign pop_lo      = lane[0].pop_rdy & lane[0].pop_vld;
  assign pop_hi      = lane[1].pop_rdy & lane[1].pop_vld;
  assign pop_size    = half_cnt_t'(pop_lo) + half_cnt_t'(pop_hi);
  assign buf_cnt_nxt = buf_cnt + push_size - pop_size;

  // command packet
  assign cmd_req_vld = (state == SEQ_WAIT_CMD) & cmd_vld;
  assign cmd_rdy     = (state == SEQ_WAIT_CMD) & wr_req_rdy;
  assign cmd_pop     = cmd_vld & cmd_rdy;

  // data packets carry a lone half only when one is left
  assign remain   = size_p1 - popped_cnt;
  assign single   = (remain == half_cnt_t'(1));
  assign pop_mask = single ? 2'b01 : 2'b11;

  assign data_req_vld = (state == SEQ_DATA) &
                        (single ? (send_half ? lane[1].pop_vld : lane[0].pop_vld)
                                : (lane[0].pop_vld & lane[1].pop_vld));
  assign data_go      = data_req_vld & wr_req_rdy;

  assign lane[0].pop_rdy = data_go & (~single | ~send_half);
  assign lane[1].pop_rdy = data_go & (~single | send_half);

  // earlier-written half lands low
  assign data_lo = send_half ? lane[1].pop_pd : lane[0].pop_pd;
  assign data_hi = single ? '0 : (send_half ? lane[0].pop_pd : lane[1].pop_pd);

  assign data_pop   = pop_lo | pop_hi;
  assign popped_nxt = popped_cnt + pop_size;
  assign data_done  = data_pop & (popped_nxt == size_p1);
  assign done       = data_done & last_cmd;

  assign wr_req_vld = cmd_req_vld | data_req_vld;
  assign wr_req_pd  = (state == SEQ_WAIT_CMD) ? req_pd_t'(cmd_pd)
                                              : {1'b1, pop_mask, data_hi, data_lo};

  // ==========================================================================
  // fsm
  // ==========================================================================
  always_comb begin
    state_nxt = state;
    case (state)
      SEQ_OPEN: begin
        if (buf_cnt != '0) begin
          state_nxt = SEQ_WAIT_CMD;
        end
      end
      SEQ_WAIT_CMD: begin
        if (cmd_pop) begin
          state_nxt = SEQ_DATA;
        end
      end
      SEQ_DATA: begin
        if (data_done) begin
          state_nxt = (buf_cnt_nxt != '0) ? SEQ_WAIT_CMD : SEQ_OPEN;
        end
      end
      default: state_nxt = SEQ_OPEN;
    endcase
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state      <= SEQ_OPEN;
      send_half  <= 1'b0;
      buf_cnt    <= '0;
      popped_cnt <= '0;
      size_p1    <= '0;
      last_cmd   <= 1'b0;
    end else begin
      state   <= state_nxt;
      buf_cnt <= buf_cnt_nxt;
      if (done) begin
        send_half <= 1'b0;
      end else if (data_pop & single) begin
        send_half <= ~send_half;
      end
      if (data_done) begin
        popped_cnt <= '0;
      end else if (data_pop) begin
        popped_cnt <= popped_nxt;
      end
      if (cmd_pop) begin
        last_cmd <= cmd_pd[SW+AW];
        size_p1  <= half_cnt_t'(cmd_pd[AW +: SW]) + 1'b1;
      end
    end
  end

  // ==========================================================================
  // stall counter and result registers
  // ==========================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (done) begin
      stall_cnt <= '0;  // zero from the cycle after done
    end else if (perf_en & wr_req_vld & ~wr_req_rdy) begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      d0_stall_cnt <= '0;
      d1_stall_cnt <= '0;
    end else if (done) begin
      if (consumer) begin
        d1_stall_cnt <= stall_cnt;
      end else begin
        d0_stall_cnt <= stall_cnt;
      end
    end
  end

  // data only after a command and with halves counted in the lanes
  a_data_not_open: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    wr_req_vld && wr_req_pd[$bits(req_pd_t)-1] |-> (state != SEQ_OPEN) && (buf_cnt != '0)
  );

  a_popped_in_range: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (state == SEQ_DATA) |-> popped_cnt < size_p1
  );

endmodule

`default_nettype wire

// File: design/rbk_wr_line_split.sv
`timescale 1ns/100ps
`default_nettype none

`include "rbk_wr_defs.svh"

module rbk_wr_line_split (
  input  wire                       nvdla_core_clk,
  input  wire                       nvdla_core_rstn,
  input  wire                       data_vld,
  input  wire rbk_wr_pkg::line_pd_t data_pd,
  output logic                      data_rdy,
  rbk_wr_lane_if.wr                 lane [2],
  input  wire                       done
);
  import rbk_wr_pkg::*;

  localparam int HW = `RBK_HALF_DW;

  line_mask_t data_mask;
  half_t      lo_half;
  half_t      hi_half;
  logic       full_line;
  logic       push;
  logic       fill_half;  // lane that takes the next single half

  assign data_mask = data_pd[2*HW +: 2];
  assign lo_half   = data_pd[HW-1:0];
  assign hi_half   = data_pd[2*HW-1:HW];
  assign full_line = data_mask[1];

  // ==========================================================================
  // lane steering
  // ==========================================================================

  // full line needs both lanes, single half only the toggled one
  assign data_rdy = full_line ? (lane[0].push_rdy & lane[1].push_rdy)
                              : (fill_half ? lane[1].push_rdy : lane[0].push_rdy);
  assign push     = data_vld & data_rdy;

  assign lane[0].push_vld = push & (full_line | ~fill_half);
  assign lane[1].push_vld = push & (full_line | fill_half);

  // earlier half goes to the toggled lane
  assign lane[0].push_pd = fill_half ? hi_half : lo_half;
  assign lane[1].push_pd = fill_half ? lo_half : hi_half;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      fill_half <= 1'b0;
    end else if (done) begin
      fill_half <= 1'b0;  // new layer starts in lane 0
    end else if (push & ~full_line) begin
      fill_half <= ~fill_half;
    end
  end

  // only full lines or a lone low half
  a_mask_legal: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    data_vld |-> (data_mask == 2'b11) || (data_mask == 2'b01)
  );

endmodule

`default_nettype wire

// File: design/rbk_wr_cmd_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "rbk_wr_defs.svh"

module rbk_wr_cmd_fifo #(
  parameter int DEPTH = `RBK_CMD_DEPTH
) (
  input  wire                      nvdla_core_clk,
  input  wire                      nvdla_core_rstn,
  input  wire                      in_vld,
  output logic                     in_rdy,
  input  wire rbk_wr_pkg::cmd_pd_t in_pd,
  output logic                     out_vld,
  input  wire                      out_rdy,
  output rbk_wr_pkg::cmd_pd_t      out_pd
);
  import rbk_wr_pkg::*;

  localparam int AW = $clog2(DEPTH);

  cmd_pd_t       mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          push;
  logic          pop;

  assign in_rdy  = (count != (AW+1)'(DEPTH));
  assign out_vld = (count != '0);
  assign out_pd  = mem[rd_ptr];
  assign push    = in_vld & in_rdy;
  assign pop     = out_vld & out_rdy;

  always_ff @(posedge nvdla_core_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_pd;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (AW+1)'(push) - (AW+1)'(pop);
    end
  end

  // a clean command at the head, pointers and storage agree
  a_out_known: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    out_vld |-> !$isunknown(out_pd)
  );

endmodule

`default_nettype wire

// File: design/rbk_wr_lane_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "rbk_wr_defs.svh"

module rbk_wr_lane_fifo (
  input wire          nvdla_core_clk,
  input wire          nvdla_core_rstn,
  rbk_wr_lane_if.fifo lane
);
  import rbk_wr_pkg::*;

  localparam int DEPTH = `RBK_LANE_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  half_t         mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          push;
  logic          pop;

  assign lane.push_rdy = (count != (AW+1)'(DEPTH));
  assign lane.pop_vld  = (count != '0);
  assign lane.pop_pd   = mem[rd_ptr];

  assign push = lane.push_vld & lane.push_rdy;
  assign pop  = lane.pop_rdy & lane.pop_vld;

  always_ff @(posedge nvdla_core_clk) begin
    if (push) begin
      mem[wr_ptr] <= lane.push_pd;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (AW+1)'(push) - (AW+1)'(pop);  // entry shows next cycle
    end
  end

  // splitter only raises a lane valid once it has seen that lane ready
  a_no_push_full: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    lane.push_vld |-> lane.push_rdy
  );

endmodule

`default_nettype wire

// File: design/rbk_wr_lane_if.sv
`timescale 1ns/100ps
`default_nettype none

interface rbk_wr_lane_if;
  import rbk_wr_pkg::*;

  logic  push_vld;
  logic  push_rdy;
  half_t push_pd;
  logic  pop_vld;
  logic  pop_rdy;
  half_t pop_pd;

  modport fifo (
    input  push_vld, push_pd, pop_rdy,
    output push_rdy, pop_vld, pop_pd
  );

  // line splitter side
  modport wr (
    output push_vld, push_pd,
    input  push_rdy
  );

  // sequencer side, push pair watched for the buffered-half count
  modport rd (
    output pop_rdy,
    input  pop_vld, pop_pd, push_vld, push_rdy
  );

endinterface

`default_nettype wire

// File: design/rbk_wr_pkg.sv
`default_nettype none

`include "rbk_wr_defs.svh"

package rbk_wr_pkg;

  // one half-line of data
  typedef logic [`RBK_HALF_DW-1:0] half_t;

  // 2'b11 full line, 2'b01 low half only
  typedef logic [1:0] line_mask_t;

  // {mask, upper half, lower half}
  typedef logic [2*`RBK_HALF_DW+1:0] line_pd_t;

  // {last, size, addr}
  typedef logic [`RBK_SIZE_W+`RBK_ADDR_W:0] cmd_pd_t;

  // kind bit on top, 0 = command, 1 = data
  typedef logic [2*`RBK_HALF_DW+2:0] req_pd_t;

  typedef logic [`RBK_SIZE_W:0] half_cnt_t;  // holds size+1
  typedef logic [31:0]          stall_cnt_t;

  typedef enum logic [1:0] {
    SEQ_OPEN,
    SEQ_WAIT_CMD,
    SEQ_DATA
  } seq_state_e;

endpackage

`default_nettype wire

// File: design/rbk_wr_defs.svh
`ifndef RBK_WR_DEFS_SVH
`define RBK_WR_DEFS_SVH

// ==========================================================================
// write request widths and depths
// ==========================================================================

// one half of a data line
`define RBK_HALF_DW     64

// entries per half-lane fifo
`define RBK_LANE_DEPTH  8

// entries in the command fifo
`define RBK_CMD_DEPTH   4

// command fields
`define RBK_SIZE_W      13  // size in halves, minus one
`define RBK_ADDR_W      32

`endif
